// File: verilog/rvIsaPkg.sv
// RV32IM instruction set constants shared by the decode stage
package rvIsaPkg;

  // one machine word
  localparam int instW = 32;
  localparam int regAddrW = 5;
  localparam int regCnt = 1 << regAddrW;

  // major opcodes, inst[6:0]
  localparam logic [6:0] opLui = 7'b0110111;
  localparam logic [6:0] opAuipc = 7'b0010111;
  localparam logic [6:0] opJal = 7'b1101111;
  localparam logic [6:0] opJalr = 7'b1100111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opOpImm = 7'b0010011;
  localparam logic [6:0] opOp = 7'b0110011;
  localparam logic [6:0] opSystem = 7'b1110011;

  // V is the system / CSR form
  typedef enum logic [2:0] {
    fmtI = 3'b000,
    fmtU = 3'b001,
    fmtS = 3'b010,
    fmtJ = 3'b011,
    fmtB = 3'b100,
    fmtR = 3'b101,
    fmtV = 3'b110
  } instFmt;

  // fixed system encodings
  localparam logic [instW-1:0] instEcall = 32'h0000_0073;
  localparam logic [instW-1:0] instEbreak = 32'h0010_0073;
  localparam logic [instW-1:0] instMret = 32'h3020_0073;

  // machine CSR addresses
  localparam logic [11:0] csrMepc = 12'h341;
  localparam logic [11:0] csrMcause = 12'h342;
  localparam logic [11:0] csrMstatus = 12'h300;
  localparam logic [11:0] csrMtvec = 12'h305;

endpackage

// File: verilog/rvCtrlPkg.sv
// control encodings handed from decode to the execute, memory and writeback stages
package rvCtrlPkg;

  localparam int maskW = 32;
  localparam int wmaskW = 8;

  // funct3 slot unused by branches, marks a non-branch
  localparam logic [2:0] bOpNone = 3'b010;

  typedef enum logic [4:0] {
    aluAdd,
    aluSub,
    aluMul,
    aluDiv,
    aluDivu,
    aluRem,
    aluRemu,
    aluSles,
    aluUles,
    aluAnd,
    aluOr,
    aluXor,
    aluSl,
    aluSr,
    aluSsr,
    aluImm,
    aluSrc
  } aluOpT;

  typedef enum logic [1:0] {
    pcNext = 2'd0,
    pcRel = 2'd1,
    pcReg = 2'd2,
    pcTrap = 2'd3
  } pcOpT;

  typedef enum logic {src1Rs1 = 1'b0, src1Pc = 1'b1} src1OpT;

  typedef enum logic [1:0] {src2Rs2 = 2'd0, src2Imm = 2'd1, src2Csr = 2'd2} src2OpT;

  typedef enum logic [1:0] {wdAlu = 2'd0, wdLoad = 2'd1, wdPc4 = 2'd2, wdCsr = 2'd3} wdOpT;

  typedef enum logic [1:0] {
    csrIdxMepc = 2'd0,
    csrIdxMcause = 2'd1,
    csrIdxMstatus = 2'd2,
    csrIdxMtvec = 2'd3
  } csrIdxT;

endpackage

// File: verilog/immGen.sv
// immediate generator that finds the instruction format and builds the 32-bit immediate
module immGen import rvIsaPkg::*; (
  input  logic [instW-1:0] inst,
  output logic [instW-1:0] imm
);

  instFmt fmt;

  // unknown opcodes map to R and so get a zero immediate
  always_comb begin
    case (inst[6:0])
      opLui, opAuipc: fmt = fmtU;
      opOpImm, opLoad, opJalr: fmt = fmtI;
      opJal: fmt = fmtJ;
      opStore: fmt = fmtS;
      opBranch: fmt = fmtB;
      opSystem: fmt = fmtV;
      default: fmt = fmtR;
    endcase
  end

  always_comb begin
    case (fmt)
      fmtI: imm = {{20{inst[31]}}, inst[31:20]};
      fmtU: imm = {inst[31:12], 12'b0};
      fmtS: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      // branch offsets are always even
      fmtB: begin
        imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      fmtJ: begin
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      // csr address, not sign extended
      fmtV: imm = {20'b0, inst[31:20]};
      default: imm = '0;
    endcase
  end

endmodule

// File: verilog/ctrlDecode.sv
// control decoder that turns an instruction into ALU, branch, memory, writeback and system controls
module ctrlDecode import rvIsaPkg::*, rvCtrlPkg::*; (
  input  logic [instW-1:0]    inst,
  output logic [regAddrW-1:0] rs1,
  output logic [regAddrW-1:0] rs2,
  output logic [regAddrW-1:0] rd,
  output aluOpT               aluOp,
  output logic [2:0]          bOp,
  output pcOpT                pcOp,
  output src1OpT              src1Op,
  output src2OpT              src2Op,
  output wdOpT                wdOp,
  output logic                rdWe,
  output logic                memRen,
  output logic                memWen,
  output logic [wmaskW-1:0]   wmask,
  output logic [maskW-1:0]    rmask,
  output logic                loadSigned,
  output csrIdxT              csrIdx,
  output logic                csrWe,
  output logic                ecall,
  output logic                ebreak,
  output logic                mret
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       csrRw;
  logic       csrRs;
  logic       rdWrites;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd = inst[11:7];

  assign ecall = (inst == instEcall);
  assign ebreak = (inst == instEbreak);
  assign mret = (inst == instMret);
  assign csrRw = (opcode == opSystem) && (funct3 == 3'b001);
  assign csrRs = (opcode == opSystem) && (funct3 == 3'b010);

  // alu operation
  always_comb begin
    aluOp = aluAdd;
    case (opcode)
      opLui: aluOp = aluImm;
      opOp: begin
        if (funct7 == 7'b0000001) begin
          // high-half multiplies share the MUL unit
          case (funct3)
            3'b100: aluOp = aluDiv;
            3'b101: aluOp = aluDivu;
            3'b110: aluOp = aluRem;
            3'b111: aluOp = aluRemu;
            default: aluOp = aluMul;
          endcase
        end else begin
          case (funct3)
            3'b000: aluOp = funct7[5] ? aluSub : aluAdd;
            3'b001: aluOp = aluSl;
            3'b010: aluOp = aluSles;
            3'b011: aluOp = aluUles;
            3'b100: aluOp = aluXor;
            3'b101: aluOp = funct7[5] ? aluSsr : aluSr;
            3'b110: aluOp = aluOr;
            default: aluOp = aluAnd;
          endcase
        end
      end
      opOpImm: begin
        case (funct3)
          3'b001: aluOp = aluSl;
          3'b010: aluOp = aluSles;
          3'b011: aluOp = aluUles;
          3'b100: aluOp = aluXor;
          // srai vs srli lives in funct7
          3'b101: aluOp = (funct7 == 7'b0100000) ? aluSsr : aluSr;
          3'b110: aluOp = aluOr;
          3'b111: aluOp = aluAnd;
          default: aluOp = aluAdd;
        endcase
      end
      opBranch: begin
        case (funct3)
          3'b100, 3'b101: aluOp = aluSles;
          3'b110, 3'b111: aluOp = aluUles;
          default: aluOp = aluSub;
        endcase
      end
      opSystem: begin
        if (csrRs) begin
          aluOp = aluOr;
        end else if (csrRw) begin
          aluOp = aluSrc;
        end else begin
          aluOp = aluImm;
        end
      end
      default: aluOp = aluAdd;
    endcase
  end

  assign bOp = (opcode == opBranch) ? funct3 : bOpNone;

  always_comb begin
    case (opcode)
      opBranch, opJal: pcOp = pcRel;
      opJalr: pcOp = pcReg;
      default: pcOp = pcNext;
    endcase
    if (ecall || mret) begin
      pcOp = pcTrap;
    end
  end

  assign src1Op = (opcode == opAuipc || opcode == opJal) ? src1Pc : src1Rs1;

  always_comb begin
    case (opcode)
      opLui, opAuipc, opJal, opJalr, opLoad, opStore, opOpImm: src2Op = src2Imm;
      opSystem: src2Op = src2Csr;
      default: src2Op = src2Rs2;
    endcase
  end

  // writeback source and enable
  always_comb begin
    case (opcode)
      opLoad: wdOp = wdLoad;
      opJal, opJalr: wdOp = wdPc4;
      opSystem: wdOp = (csrRw || csrRs) ? wdCsr : wdAlu;
      default: wdOp = wdAlu;
    endcase
    case (opcode)
      opLui, opAuipc, opJal, opJalr, opLoad, opOpImm, opOp: rdWrites = 1'b1;
      opSystem: rdWrites = csrRw || csrRs;
      default: rdWrites = 1'b0;
    endcase
  end

  assign rdWe = rdWrites && (rd != '0);

  assign memRen = (opcode == opLoad);
  assign memWen = (opcode == opStore);
  assign loadSigned = (funct3 == 3'b000) || (funct3 == 3'b001);

  always_comb begin
    case (funct3)
      3'b000: wmask = 8'b0000_0001;
      3'b001: wmask = 8'b0000_0011;
      default: wmask = 8'b0000_1111;
    endcase
    case (funct3)
      3'b000, 3'b100: rmask = 32'h0000_00ff;
      3'b001, 3'b101: rmask = 32'h0000_ffff;
      default: rmask = 32'hffff_ffff;
    endcase
  end

  // ecall records its cause, mret reads back the saved pc
  always_comb begin
    case (inst[31:20])
      csrMepc: csrIdx = csrIdxMepc;
      csrMcause: csrIdx = csrIdxMcause;
      csrMstatus: csrIdx = csrIdxMstatus;
      default: csrIdx = csrIdxMtvec;
    endcase
    if (ecall) begin
      csrIdx = csrIdxMcause;
    end else if (mret) begin
      csrIdx = csrIdxMepc;
    end
  end

  assign csrWe = csrRw || csrRs || ecall;

endmodule

// File: verilog/regFile.sv
// integer register file with two combinational reads and one clocked write port
module regFile import rvIsaPkg::*; (
  input  logic                clk,
  input  logic                arstN,
  input  logic [regAddrW-1:0] rs1,
  input  logic [regAddrW-1:0] rs2,
  input  logic                wbWe,
  input  logic [regAddrW-1:0] wbAddr,
  input  logic [instW-1:0]    wbData,
  output logic [instW-1:0]    rs1Data,
  output logic [instW-1:0]    rs2Data
);

  // x0 has no storage
  logic [instW-1:0] regs [1:regCnt-1];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < regCnt; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWe && (wbAddr != '0)) begin
      regs[wbAddr] <= wbData;
    end
  end

  // no bypass, a same-cycle write shows up next cycle
  assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: verilog/operandMux.sv
// operand mux that selects the ALU sources and registers the decode results
module operandMux import rvIsaPkg::*, rvCtrlPkg::*; (
  input  logic                clk,
  input  logic                arstN,
  input  logic                instValid,
  input  logic [instW-1:0]    pc,
  input  logic [instW-1:0]    imm,
  input  logic [instW-1:0]    rs1Data,
  input  logic [instW-1:0]    rs2Data,
  input  logic [regAddrW-1:0] decRd,
  input  aluOpT               decAluOp,
  input  logic [2:0]          decBOp,
  input  pcOpT                decPcOp,
  input  src1OpT              decSrc1Op,
  input  src2OpT              decSrc2Op,
  input  wdOpT                decWdOp,
  input  logic                decRdWe,
  input  logic                decMemRen,
  input  logic                decMemWen,
  input  logic [wmaskW-1:0]   decWmask,
  input  logic [maskW-1:0]    decRmask,
  input  logic                decLoadSigned,
  input  csrIdxT              decCsrIdx,
  input  logic                decCsrWe,
  input  logic                decEcall,
  input  logic                decEbreak,
  input  logic                decMret,
  output logic                outValid,
  output logic [instW-1:0]    src1,
  output logic [instW-1:0]    src2,
  output logic [instW-1:0]    storeData,
  output logic [instW-1:0]    outPc,
  output logic [instW-1:0]    outImm,
  output logic [regAddrW-1:0] rd,
  output aluOpT               aluOp,
  output logic [2:0]          bOp,
  output pcOpT                pcOp,
  output src1OpT              src1Op,
  output src2OpT              src2Op,
  output wdOpT                wdOp,
  output logic                rdWe,
  output logic                memRen,
  output logic                memWen,
  output logic [wmaskW-1:0]   wmask,
  output logic [maskW-1:0]    rmask,
  output logic                loadSigned,
  output csrIdxT              csrIdx,
  output logic                csrWe,
  output logic                ecall,
  output logic                ebreak,
  output logic                mret
);

  logic [instW-1:0] src1Nxt;
  logic [instW-1:0] src2Nxt;

  assign src1Nxt = (decSrc1Op == src1Pc) ? pc : rs1Data;

  // the V format already carries the csr address in imm
  always_comb begin
    case (decSrc2Op)
      src2Imm, src2Csr: src2Nxt = imm;
      default: src2Nxt = rs2Data;
    endcase
  end

  // enables and flags only live for one cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      rdWe <= 1'b0;
      memRen <= 1'b0;
      memWen <= 1'b0;
      csrWe <= 1'b0;
      ecall <= 1'b0;
      ebreak <= 1'b0;
      mret <= 1'b0;
    end else begin
      outValid <= instValid;
      rdWe <= instValid && decRdWe;
      memRen <= instValid && decMemRen;
      memWen <= instValid && decMemWen;
      csrWe <= instValid && decCsrWe;
      ecall <= instValid && decEcall;
      ebreak <= instValid && decEbreak;
      mret <= instValid && decMret;
    end
  end

  // payload holds until the next strobe
  always_ff @(posedge clk) begin
    if (instValid) begin
      src1 <= src1Nxt;
      src2 <= src2Nxt;
      storeData <= rs2Data;
      outPc <= pc;
      outImm <= imm;
      rd <= decRd;
      aluOp <= decAluOp;
      bOp <= decBOp;
      pcOp <= decPcOp;
      src1Op <= decSrc1Op;
      src2Op <= decSrc2Op;
      wdOp <= decWdOp;
      wmask <= decWmask;
      rmask <= decRmask;
      loadSigned <= decLoadSigned;
      csrIdx <= decCsrIdx;
    end
  end

endmodule

// File: verilog/decodeStage.sv
// decode stage top that ties the immediate, control, register file and operand blocks together
module decodeStage import rvIsaPkg::*, rvCtrlPkg::*; (
  input  logic                clk,
  input  logic                arstN,
  input  logic                instValid,
  input  logic [instW-1:0]    inst,
  input  logic [instW-1:0]    pc,
  input  logic                wbWe,
  input  logic [regAddrW-1:0] wbAddr,
  input  logic [instW-1:0]    wbData,
  output logic                outValid,
  output logic [instW-1:0]    src1,
  output logic [instW-1:0]    src2,
  output logic [instW-1:0]    storeData,
  output logic [instW-1:0]    outPc,
  output logic [instW-1:0]    outImm,
  output logic [regAddrW-1:0] rd,
  output aluOpT               aluOp,
  output logic [2:0]          bOp,
  output pcOpT                pcOp,
  output src1OpT              src1Op,
  output src2OpT              src2Op,
  output wdOpT                wdOp,
  output logic                rdWe,
  output logic                memRen,
  output logic                memWen,
  output logic [wmaskW-1:0]   wmask,
  output logic [maskW-1:0]    rmask,
  output logic                loadSigned,
  output csrIdxT              csrIdx,
  output logic                csrWe,
  output logic                ecall,
  output logic                ebreak,
  output logic                mret
);

  logic [instW-1:0]    imm;
  logic [regAddrW-1:0] rs1;
  logic [regAddrW-1:0] rs2;
  logic [instW-1:0]    rs1Data;
  logic [instW-1:0]    rs2Data;
  logic [regAddrW-1:0] decRd;
  aluOpT               decAluOp;
  logic [2:0]          decBOp;
  pcOpT                decPcOp;
  src1OpT              decSrc1Op;
  src2OpT              decSrc2Op;
  wdOpT                decWdOp;
  logic                decRdWe;
  logic                decMemRen;
  logic                decMemWen;
  logic [wmaskW-1:0]   decWmask;
  logic [maskW-1:0]    decRmask;
  logic                decLoadSigned;
  csrIdxT              decCsrIdx;
  logic                decCsrWe;
  logic                decEcall;
  logic                decEbreak;
  logic                decMret;

  immGen immGen_i (
    .inst (inst),
    .imm  (imm)
  );

  ctrlDecode ctrlDecode_i (
    .inst       (inst),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (decRd),
    .aluOp      (decAluOp),
    .bOp        (decBOp),
    .pcOp       (decPcOp),
    .src1Op     (decSrc1Op),
    .src2Op     (decSrc2Op),
    .wdOp       (decWdOp),
    .rdWe       (decRdWe),
    .memRen     (decMemRen),
    .memWen     (decMemWen),
    .wmask      (decWmask),
    .rmask      (decRmask),
    .loadSigned (decLoadSigned),
    .csrIdx     (decCsrIdx),
    .csrWe      (decCsrWe),
    .ecall      (decEcall),
    .ebreak     (decEbreak),
    .mret       (decMret)
  );

  regFile regFile_i (
    .clk     (clk),
    .arstN   (arstN),
    .rs1     (rs1),
    .rs2     (rs2),
    .wbWe    (wbWe),
    .wbAddr  (wbAddr),
    .wbData  (wbData),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data)
  );

  operandMux operandMux_i (
    .clk           (clk),
    .arstN         (arstN),
    .instValid     (instValid),
    .pc            (pc),
    .imm           (imm),
    .rs1Data       (rs1Data),
    .rs2Data       (rs2Data),
    .decRd         (decRd),
    .decAluOp      (decAluOp),
    .decBOp        (decBOp),
    .decPcOp       (decPcOp),
    .decSrc1Op     (decSrc1Op),
    .decSrc2Op     (decSrc2Op),
    .decWdOp       (decWdOp),
    .decRdWe       (decRdWe),
    .decMemRen     (decMemRen),
    .decMemWen     (decMemWen),
    .decWmask      (decWmask),
    .decRmask      (decRmask),
    .decLoadSigned (decLoadSigned),
    .decCsrIdx     (decCsrIdx),
    .decCsrWe      (decCsrWe),
    .decEcall      (decEcall),
    .decEbreak     (decEbreak),
    .decMret       (decMret),
    .outValid      (outValid),
    .src1          (src1),
    .src2          (src2),
    .storeData     (storeData),
    .outPc         (outPc),
    .outImm        (outImm),
    .rd            (rd),
    .aluOp         (aluOp),
    .bOp           (bOp),
    .pcOp          (pcOp),
    .src1Op        (src1Op),
    .src2Op        (src2Op),
    .wdOp          (wdOp),
    .rdWe          (rdWe),
    .memRen        (memRen),
    .memWen        (memWen),
    .wmask         (wmask),
    .rmask         (rmask),
    .loadSigned    (loadSigned),
    .csrIdx        (csrIdx),
    .csrWe         (csrWe),
    .ecall         (ecall),
    .ebreak        (ebreak),
    .mret          (mret)
  );

endmodule

// File: test/decodeModel.svh
// reference decode rules and shadow register array for the decode stage testbench
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

  // x0 entry is never written
  logic [instW-1:0] shadowRegs [regCnt];

  function automatic logic [instW-1:0] refImm(input logic [instW-1:0] i);
    case (i[6:0])
      opLui, opAuipc: return {i[31:12], 12'h000};
      opJal: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      opBranch: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      opStore: return {{20{i[31]}}, i[31:25], i[11:7]};
      opLoad, opOpImm, opJalr: return {{20{i[31]}}, i[31:20]};
      opSystem: return {20'h00000, i[31:20]};
      default: return '0;
    endcase
  endfunction

  function automatic aluOpT refAlu(input logic [instW-1:0] i);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = i[14:12];
    f7 = i[31:25];
    if (i[6:0] == opLui) begin
      return aluImm;
    end
    if (i[6:0] == opBranch) begin
      return f3[2] ? (f3[1] ? aluUles : aluSles) : aluSub;
    end
    if (i[6:0] == opSystem) begin
      return (f3 == 3'd2) ? aluOr : ((f3 == 3'd1) ? aluSrc : aluImm);
    end
    if (i[6:0] == opOp && f7 == 7'h01) begin
      // mul, mulh, mulhsu and mulhu all map to one op
      if (!f3[2]) begin
        return aluMul;
      end
      return f3[1] ? (f3[0] ? aluRemu : aluRem) : (f3[0] ? aluDivu : aluDiv);
    end
    if (i[6:0] != opOp && i[6:0] != opOpImm) begin
      return aluAdd;
    end
    case (f3)
      3'd0: return (i[6:0] == opOp && f7[5]) ? aluSub : aluAdd;
      3'd1: return aluSl;
      3'd2: return aluSles;
      3'd3: return aluUles;
      3'd4: return aluXor;
      3'd5: return f7[5] ? aluSsr : aluSr;
      3'd6: return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  function automatic pcOpT refPcOp(input logic [instW-1:0] i);
    if (i == instEcall || i == instMret) begin
      return pcTrap;
    end
    case (i[6:0])
      opBranch, opJal: return pcRel;
      opJalr: return pcReg;
      default: return pcNext;
    endcase
  endfunction

  function automatic src2OpT refSrc2Op(input logic [6:0] op);
    if (op == opSystem) begin
      return src2Csr;
    end
    return (op == opOp || op == opBranch) ? src2Rs2 : src2Imm;
  endfunction

  // csrrw and csrrs only
  function automatic logic isCsrOp(input logic [instW-1:0] i);
    return i[6:0] == opSystem && (i[14:12] == 3'd1 || i[14:12] == 3'd2);
  endfunction

  function automatic logic refWritesRd(input logic [instW-1:0] i);
    case (i[6:0])
      opStore, opBranch: return 1'b0;
      opSystem: return isCsrOp(i);
      default: return 1'b1;
    endcase
  endfunction

  function automatic csrIdxT refCsr(input logic [11:0] addr);
    if (addr == csrMepc) begin
      return csrIdxMepc;
    end
    if (addr == csrMcause) begin
      return csrIdxMcause;
    end
    return (addr == csrMstatus) ? csrIdxMstatus : csrIdxMtvec;
  endfunction

`endif

// File: test/decodeStageTb.sv
// testbench for the decode stage, checks every output against a reference decode model
module decodeStageTb import rvIsaPkg::*, rvCtrlPkg::*; ();

  logic                clk = 1'b0;
  logic                arstN;
  logic                instValid;
  logic [instW-1:0]    inst;
  logic [instW-1:0]    pc;
  logic                wbWe;
  logic [regAddrW-1:0] wbAddr;
  logic [instW-1:0]    wbData;
  logic                outValid;
  logic [instW-1:0]    src1;
  logic [instW-1:0]    src2;
  logic [instW-1:0]    storeData;
  logic [instW-1:0]    outPc;
  logic [instW-1:0]    outImm;
  logic [regAddrW-1:0] rd;
  aluOpT               aluOp;
  logic [2:0]          bOp;
  pcOpT                pcOp;
  src1OpT              src1Op;
  src2OpT              src2Op;
  wdOpT                wdOp;
  logic                rdWe;
  logic                memRen;
  logic                memWen;
  logic [wmaskW-1:0]   wmask;
  logic [maskW-1:0]    rmask;
  logic                loadSigned;
  csrIdxT              csrIdx;
  logic                csrWe;
  logic                ecall;
  logic                ebreak;
  logic                mret;

  // expected outputs for the instruction sampled at the last rising edge
  logic                expValid = 1'b0;
  logic [instW-1:0]    expSrc1;
  logic [instW-1:0]    expSrc2;
  logic [instW-1:0]    expStore;
  logic [instW-1:0]    expPc;
  logic [instW-1:0]    expImm;
  logic [regAddrW-1:0] expRd;
  aluOpT               expAlu;
  logic [2:0]          expBOp;
  pcOpT                expPcOp;
  src1OpT              expSrc1Op;
  src2OpT              expSrc2Op;
  wdOpT                expWdOp;
  logic                expRdWe;
  logic                expMemRen;
  logic                expMemWen;
  logic [wmaskW-1:0]   expWmask;
  logic [maskW-1:0]    expRmask;
  logic                expSigned;
  csrIdxT              expCsrIdx;
  logic                expCsrWe;
  logic                expEcall;
  logic                expEbreak;
  logic                expMret;

  `include "decodeModel.svh"

  decodeStage decodeStage_i (
    .clk        (clk),
    .arstN      (arstN),
    .instValid  (instValid),
    .inst       (inst),
    .pc         (pc),
    .wbWe       (wbWe),
    .wbAddr     (wbAddr),
    .wbData     (wbData),
    .outValid   (outValid),
    .src1       (src1),
    .src2       (src2),
    .storeData  (storeData),
    .outPc      (outPc),
    .outImm     (outImm),
    .rd         (rd),
    .aluOp      (aluOp),
    .bOp        (bOp),
    .pcOp       (pcOp),
    .src1Op     (src1Op),
    .src2Op     (src2Op),
    .wdOp       (wdOp),
    .rdWe       (rdWe),
    .memRen     (memRen),
    .memWen     (memWen),
    .wmask      (wmask),
    .rmask      (rmask),
    .loadSigned (loadSigned),
    .csrIdx     (csrIdx),
    .csrWe      (csrWe),
    .ecall      (ecall),
    .ebreak     (ebreak),
    .mret       (mret)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  task automatic failWith(input string name, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    $display("Test FAILED");
    $display("FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, expVal, actVal);
    $fatal(1, "output mismatch");
  endtask

  task automatic checkField(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    assert (actVal == expVal) else failWith(name, expVal, actVal);
  endtask

  task automatic predict(input logic [instW-1:0] i, input logic [instW-1:0] p);
    logic [2:0] f3;
    f3 = i[14:12];
    expImm = refImm(i);
    expPc = p;
    expRd = i[11:7];
    expAlu = refAlu(i);
    expBOp = (i[6:0] == opBranch) ? f3 : bOpNone;
    expPcOp = refPcOp(i);
    expSrc1Op = (i[6:0] == opAuipc || i[6:0] == opJal) ? src1Pc : src1Rs1;
    expSrc2Op = refSrc2Op(i[6:0]);
    if (i[6:0] == opLoad) begin
      expWdOp = wdLoad;
    end else if (i[6:0] == opJal || i[6:0] == opJalr) begin
      expWdOp = wdPc4;
    end else begin
      expWdOp = isCsrOp(i) ? wdCsr : wdAlu;
    end
    expRdWe = refWritesRd(i) && (i[11:7] != 5'd0);
    expMemRen = (i[6:0] == opLoad);
    expMemWen = (i[6:0] == opStore);
    // byte, half, word
    expWmask = (f3 == 3'd0) ? 8'h01 : ((f3 == 3'd1) ? 8'h03 : 8'h0f);
    expRmask = (f3[1:0] == 2'd0) ? 32'hff : ((f3[1:0] == 2'd1) ? 32'hffff : 32'hffff_ffff);
    expSigned = (f3 == 3'd0 || f3 == 3'd1);
    expEcall = (i == instEcall);
    expEbreak = (i == instEbreak);
    expMret = (i == instMret);
    expCsrWe = isCsrOp(i) || expEcall;
    expCsrIdx = expEcall ? csrIdxMcause : (expMret ? csrIdxMepc : refCsr(i[31:20]));
    expSrc1 = (expSrc1Op == src1Pc) ? p : shadowRegs[i[19:15]];
    expSrc2 = (expSrc2Op == src2Rs2) ? shadowRegs[i[24:20]] : expImm;
    expStore = shadowRegs[i[24:20]];
  endtask

  // reads see the register state from before a same-edge writeback
  always @(posedge clk) begin
    if (!arstN) begin
      for (int r = 0; r < regCnt; r++) begin
        shadowRegs[r] = '0;
      end
      expValid = 1'b0;
    end else begin
      expValid = instValid;
      if (instValid) begin
        predict(inst, pc);
      end
      if (wbWe && wbAddr != '0) begin
        shadowRegs[wbAddr] = wbData;
      end
    end
  end

  always @(negedge clk) begin
    checkField("outValid", expValid, outValid);
    if (!expValid) begin
      checkField("rdWe", 0, rdWe);
      checkField("memRen", 0, memRen);
      checkField("memWen", 0, memWen);
      checkField("csrWe", 0, csrWe);
      checkField("ecall", 0, ecall);
      checkField("ebreak", 0, ebreak);
      checkField("mret", 0, mret);
    end else begin
      checkField("src1", expSrc1, src1);
      checkField("src2", expSrc2, src2);
      checkField("storeData", expStore, storeData);
      checkField("outPc", expPc, outPc);
      checkField("outImm", expImm, outImm);
      checkField("rd", expRd, rd);
      checkField("aluOp", expAlu, aluOp);
      checkField("bOp", expBOp, bOp);
      checkField("pcOp", expPcOp, pcOp);
      checkField("src1Op", expSrc1Op, src1Op);
      checkField("src2Op", expSrc2Op, src2Op);
      checkField("wdOp", expWdOp, wdOp);
      checkField("rdWe", expRdWe, rdWe);
      checkField("memRen", expMemRen, memRen);
      checkField("memWen", expMemWen, memWen);
      checkField("csrWe", expCsrWe, csrWe);
      checkField("ecall", expEcall, ecall);
      checkField("ebreak", expEbreak, ebreak);
      checkField("mret", expMret, mret);
      if (expMemWen) begin
        checkField("wmask", expWmask, wmask);
      end
      if (expMemRen) begin
        checkField("rmask", expRmask, rmask);
        checkField("loadSigned", expSigned, loadSigned);
      end
      if (expCsrWe || expMret) begin
        checkField("csrIdx", expCsrIdx, csrIdx);
      end
    end
  end

  task automatic waitOutValid();
    int n;
    n = 0;
    while (!outValid && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!outValid) begin
      $display("Test FAILED");
      $fatal(1, "timed out after 20 cycles waiting for outValid");
    end
  endtask

  task automatic issue(input logic [instW-1:0] i);
    @(negedge clk);
    instValid = 1'b1;
    inst = i;
    pc = $urandom & 32'hffff_fffc;
  endtask

  task automatic finishBurst();
    @(negedge clk);
    instValid = 1'b0;
    wbWe = 1'b0;
    waitOutValid();
    @(negedge clk);
  endtask

  task automatic writeBack(input logic [regAddrW-1:0] addr, input logic [instW-1:0] data);
    @(negedge clk);
    wbWe = 1'b1;
    wbAddr = addr;
    wbData = data;
    @(negedge clk);
    wbWe = 1'b0;
  endtask

  function automatic logic [instW-1:0] randInst(input logic [6:0] op, input logic [2:0] f3);
    logic [instW-1:0] r;
    r = $urandom;
    r[14:12] = f3;
    r[6:0] = op;
    return r;
  endfunction

  // base OP, M extension or OP-IMM, valid funct7 only
  function automatic logic [instW-1:0] randAluInst();
    logic [instW-1:0] r;
    logic [2:0]       f3;
    int               kind;
    kind = $urandom % 3;
    f3 = $urandom;
    r = randInst((kind == 2) ? opOpImm : opOp, f3);
    if (kind == 1) begin
      r[31:25] = 7'h01;
    end else if (kind == 0 || f3 == 3'd1 || f3 == 3'd5) begin
      r[31:25] = (((kind == 0 && f3 == 3'd0) || f3 == 3'd5) && $urandom % 2) ? 7'h20 : 7'h00;
    end
    return r;
  endfunction

  initial begin
    logic [11:0] csrAddr;
    void'($urandom(21648));
    arstN = 1'b0;
    instValid = 1'b1;
    inst = '0;
    pc = '0;
    wbWe = 1'b1;
    wbAddr = 5'd1;
    wbData = '1;
    // strobes and a writeback while in reset leave no trace
    for (int c = 0; c < 8; c++) begin
      case (c)
        0: inst = instEcall;
        1: inst = instEbreak;
        2: inst = instMret;
        3: inst = {12'h004, 5'd2, 3'd2, 5'd1, opLoad};
        4: inst = {7'h00, 5'd3, 5'd2, 3'd2, 5'd0, opStore};
        default: inst = {csrMtvec, 5'd2, 3'd1, 5'd1, opSystem};
      endcase
      @(negedge clk);
    end
    arstN = 1'b1;
    instValid = 1'b0;
    wbWe = 1'b0;

    // every register reads zero after reset
    for (int r = 0; r < regCnt; r++) begin
      issue({7'h00, 5'(31 - r), 5'(r), 3'd0, 5'd0, opOp});
    end
    finishBurst();

    for (int n = 0; n < 40; n++) begin
      writeBack($urandom, $urandom);
    end
    writeBack(5'd0, $urandom | 32'h1);
    issue({7'h00, 5'd0, 5'd0, 3'd0, 5'd1, opOp});
    finishBurst();

    // gaps, back-to-back strobes and same-cycle writebacks
    for (int n = 0; n < 200; n++) begin
      @(negedge clk);
      instValid = (n == 199) || ($urandom % 4 != 0);
      inst = randAluInst();
      pc = $urandom & 32'hffff_fffc;
      wbWe = $urandom % 2;
      wbAddr = $urandom;
      wbData = $urandom;
    end
    finishBurst();

    for (int n = 0; n < 8; n++) begin
      issue(randInst(opLui, $urandom));
      issue(randInst(opAuipc, $urandom));
      issue(randInst(opJal, $urandom));
      issue(randInst(opJalr, 3'd0));
      issue(randInst(opLoad, 3'd2));
      issue(randInst(opStore, 3'd2));
      for (int f3 = 0; f3 < 8; f3++) begin
        if (f3 != 2 && f3 != 3) begin
          issue(randInst(opBranch, f3));
        end
      end
    end
    finishBurst();

    // each load and store width
    for (int f3 = 0; f3 < 8; f3++) begin
      if (f3 != 3 && f3 < 6) begin
        issue(randInst(opLoad, f3));
      end
      if (f3 < 3) begin
        issue(randInst(opStore, f3));
      end
    end
    finishBurst();

    issue(instEcall);
    issue(instEbreak);
    issue(instMret);
    for (int k = 0; k < 4; k++) begin
      case (k)
        0: csrAddr = csrMepc;
        1: csrAddr = csrMcause;
        2: csrAddr = csrMstatus;
        default: csrAddr = csrMtvec;
      endcase
      issue({csrAddr, 5'($urandom), 3'd1, 5'($urandom), opSystem});
      issue({csrAddr, 5'($urandom), 3'd2, 5'($urandom), opSystem});
      issue({csrAddr, 5'($urandom), 3'd2, 5'd0, opSystem});
    end
    finishBurst();

    repeat (3) @(negedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+test
verilog/rvIsaPkg.sv
verilog/rvCtrlPkg.sv
verilog/immGen.sv
verilog/ctrlDecode.sv
verilog/regFile.sv
verilog/operandMux.sv
verilog/decodeStage.sv
test/decodeStageTb.sv
